// File: hw/datapathPkg.sv
package datapathPkg;

	// Number of general registers the strobe vectors are sized for
	localparam int defaultRegisterCount = 16;

	typedef logic [31:0] dataWord;

	// Full Z contents, multiply fills both halves
	typedef struct packed {
		dataWord high;
		dataWord low;
	} zResult;

	typedef enum logic [4:0] {
		opAdd  = 5'd0,
		opSub  = 5'd1,
		opAnd  = 5'd2,
		opOr   = 5'd3,
		opShr  = 5'd4,
		opShra = 5'd5,
		opShl  = 5'd6,
		opRor  = 5'd7,
		opRol  = 5'd8,
		opNeg  = 5'd9,
		opNot  = 5'd10,
		opMul  = 5'd11
	} aluOperation;

	// Out strobes, bus priority runs from registerOut[0] up to mdrOut
	typedef struct packed {
		logic mdrOut;
		logic pcOut;
		logic zLowOut;
		logic zHighOut;
		logic loOut;
		logic hiOut;
		logic [defaultRegisterCount-1:0] registerOut;
	} busSources;

	typedef struct packed {
		logic [defaultRegisterCount-1:0] registerIn;
		logic yIn;
		logic zIn;
		logic hiIn;
		logic loIn;
		logic pcIn;
		logic marIn;
		logic mdrIn;
		logic irIn;
	} busSinks;

	typedef struct packed {
		busSources sources;
		busSinks sinks;
		aluOperation operation;
		logic read;   // MDR takes memory data instead of the bus
		logic incPc;
	} datapathControl;

endpackage

// File: hw/busRegister.sv
module busRegister #(
	parameter type payloadType = logic [31:0]
) (
	input logic clk,
	input logic reset,
	input logic load,
	input payloadType dataIn,
	output payloadType dataOut
);

	// Captures its input only on edges where the load strobe is high
	always_ff @(posedge clk) begin
		if (reset) begin
			dataOut <= '0;
		end else if (load) begin
			dataOut <= dataIn;
		end
	end

endmodule

// File: hw/registerFile.sv
module registerFile import datapathPkg::*; #(
	parameter int registerCount = defaultRegisterCount
) (
	input logic clk,
	input logic reset,
	input logic [registerCount-1:0] registerIn,
	input dataWord busData,
	output dataWord registers [registerCount]
);

	// R0 is a constant zero source for the bus
	assign registers[0] = '0;

	genvar i;
	generate
		for (i = 1; i < registerCount; i++) begin : gRegister
			busRegister #(
				.payloadType(dataWord)
			) generalRegister (
				.clk(clk),
				.reset(reset),
				.load(registerIn[i]),
				.dataIn(busData),
				.dataOut(registers[i])
			);
		end
	endgenerate

endmodule

// File: hw/programCounter.sv
module programCounter import datapathPkg::*; (
	input logic clk,
	input logic reset,
	input logic pcIn,
	input logic incPc,
	input dataWord busData,
	output dataWord pcValue
);

	// Increment wins over a bus load in the same cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			pcValue <= '0;
		end else if (incPc) begin
			pcValue <= pcValue + 32'd1;
		end else if (pcIn) begin
			pcValue <= busData;
		end
	end

endmodule

// File: hw/memoryInterface.sv
module memoryInterface import datapathPkg::*; (
	input logic clk,
	input logic reset,
	input logic marIn,
	input logic mdrIn,
	input logic read,
	input dataWord busData,
	input dataWord memDataIn,
	output dataWord memAddress,
	output dataWord mdrValue
);

	dataWord mdrInput;

	// MDR source select, memory on a read cycle and the bus otherwise
	assign mdrInput = read ? memDataIn : busData;

	busRegister #(
		.payloadType(dataWord)
	) marRegister (
		.clk(clk),
		.reset(reset),
		.load(marIn),
		.dataIn(busData),
		.dataOut(memAddress)
	);

	busRegister #(
		.payloadType(dataWord)
	) mdrRegister (
		.clk(clk),
		.reset(reset),
		.load(mdrIn),
		.dataIn(mdrInput),
		.dataOut(mdrValue)
	);

endmodule

// File: hw/busSelector.sv
module busSelector import datapathPkg::*; #(
	parameter int registerCount = defaultRegisterCount
) (
	input busSources sources,
	input dataWord registers [registerCount],
	input dataWord hiValue,
	input dataWord loValue,
	input dataWord pcValue,
	input dataWord mdrValue,
	input zResult zValue,
	output dataWord busData
);

	// Registers first, then HI, LO, Z high, Z low, PC and MDR
	localparam int sourceCount = registerCount + 6;
	localparam int indexWidth = $clog2(sourceCount);

	logic [sourceCount-1:0] strobes;
	logic [indexWidth-1:0] sourceIndex;
	logic sourceValid;
	dataWord sourceValues [sourceCount];

	// Register strobes above registerCount are dropped here
	assign strobes = {sources.mdrOut, sources.pcOut, sources.zLowOut, sources.zHighOut,
		sources.loOut, sources.hiOut, sources.registerOut[registerCount-1:0]};

	genvar i;
	generate
		for (i = 0; i < registerCount; i++) begin : gRegisterSource
			assign sourceValues[i] = registers[i];
		end
	endgenerate

	assign sourceValues[registerCount] = hiValue;
	assign sourceValues[registerCount+1] = loValue;
	assign sourceValues[registerCount+2] = zValue.high;
	assign sourceValues[registerCount+3] = zValue.low;
	assign sourceValues[registerCount+4] = pcValue;
	assign sourceValues[registerCount+5] = mdrValue;

	// Priority encoder, scanning downward so the lowest set index is kept
	always_comb begin
		sourceIndex = '0;
		sourceValid = 1'b0;
		for (int s = sourceCount - 1; s >= 0; s--) begin
			if (strobes[s]) begin
				sourceIndex = indexWidth'(s);
				sourceValid = 1'b1;
			end
		end
	end

	// Idle bus reads as zero
	assign busData = sourceValid ? sourceValues[sourceIndex] : '0;

endmodule

// File: hw/arithmeticUnit.sv
module arithmeticUnit import datapathPkg::*; (
	input aluOperation operation,
	input dataWord operandA,
	input dataWord operandB,
	output zResult result
);

	logic [4:0] shiftAmount;
	logic [63:0] doubledWord;
	logic [63:0] rotatedRight;
	logic [63:0] rotatedLeft;
	logic signed [63:0] product;
	dataWord highWord;
	dataWord lowWord;

	assign shiftAmount = operandB[4:0];

	// Rotates come out of a shift over two copies of the word
	assign doubledWord = {operandA, operandA};
	assign rotatedRight = doubledWord >> shiftAmount;
	assign rotatedLeft = doubledWord << shiftAmount;

	// Operands widen with sign to 64 bits before the multiply
	assign product = $signed(operandA) * $signed(operandB);

	always_comb begin
		highWord = '0;
		lowWord = '0;
		case (operation)
			opAdd: begin
				lowWord = operandA + operandB;
			end
			opSub: begin
				lowWord = operandA - operandB;
			end
			opAnd: begin
				lowWord = operandA & operandB;
			end
			opOr: begin
				lowWord = operandA | operandB;
			end
			opShr: begin
				lowWord = operandA >> shiftAmount;
			end
			opShra: begin
				lowWord = $signed(operandA) >>> shiftAmount;
			end
			opShl: begin
				lowWord = operandA << shiftAmount;
			end
			opRor: begin
				lowWord = rotatedRight[31:0];
			end
			opRol: begin
				lowWord = rotatedLeft[63:32];
			end
			// Unary operations work on the bus operand alone
			opNeg: begin
				lowWord = -operandB;
			end
			opNot: begin
				lowWord = ~operandB;
			end
			opMul: begin
				highWord = product[63:32];
				lowWord = product[31:0];
			end
			default: begin
				lowWord = '0;
			end
		endcase
	end

	assign result = '{high: highWord, low: lowWord};

endmodule

// File: hw/cpuDatapath.sv
module cpuDatapath import datapathPkg::*; #(
	parameter int registerCount = defaultRegisterCount
) (
	input logic clk,
	input logic reset,
	input datapathControl control,
	input dataWord memDataIn,
	output dataWord busData,
	output dataWord memAddress,
	output dataWord memDataOut,
	output dataWord instruction
);

	dataWord registers [registerCount];
	dataWord yValue;
	dataWord hiValue;
	dataWord loValue;
	dataWord pcValue;
	zResult zValue;
	zResult aluResult;

	registerFile #(
		.registerCount(registerCount)
	) generalRegisters (
		.clk(clk),
		.reset(reset),
		.registerIn(control.sinks.registerIn[registerCount-1:0]),
		.busData(busData),
		.registers(registers)
	);

	programCounter pc (
		.clk(clk),
		.reset(reset),
		.pcIn(control.sinks.pcIn),
		.incPc(control.incPc),
		.busData(busData),
		.pcValue(pcValue)
	);

	// MDR value leaves as memory write data and also feeds the bus
	memoryInterface memory (
		.clk(clk),
		.reset(reset),
		.marIn(control.sinks.marIn),
		.mdrIn(control.sinks.mdrIn),
		.read(control.read),
		.busData(busData),
		.memDataIn(memDataIn),
		.memAddress(memAddress),
		.mdrValue(memDataOut)
	);

	busSelector #(
		.registerCount(registerCount)
	) busMux (
		.sources(control.sources),
		.registers(registers),
		.hiValue(hiValue),
		.loValue(loValue),
		.pcValue(pcValue),
		.mdrValue(memDataOut),
		.zValue(zValue),
		.busData(busData)
	);

	// Y holds the first operand, the bus supplies the second
	arithmeticUnit alu (
		.operation(control.operation),
		.operandA(yValue),
		.operandB(busData),
		.result(aluResult)
	);

	busRegister #(.payloadType(dataWord)) yRegister (
		.clk(clk), .reset(reset), .load(control.sinks.yIn),
		.dataIn(busData), .dataOut(yValue)
	);

	busRegister #(.payloadType(zResult)) zRegister (
		.clk(clk), .reset(reset), .load(control.sinks.zIn),
		.dataIn(aluResult), .dataOut(zValue)
	);

	busRegister #(.payloadType(dataWord)) hiRegister (
		.clk(clk), .reset(reset), .load(control.sinks.hiIn),
		.dataIn(busData), .dataOut(hiValue)
	);

	busRegister #(.payloadType(dataWord)) loRegister (
		.clk(clk), .reset(reset), .load(control.sinks.loIn),
		.dataIn(busData), .dataOut(loValue)
	);

	busRegister #(.payloadType(dataWord)) irRegister (
		.clk(clk), .reset(reset), .load(control.sinks.irIn),
		.dataIn(busData), .dataOut(instruction)
	);

endmodule

// File: testbench/cpuDatapath_chk.sv
module cpuDatapathChk import datapathPkg::*; (
	input logic clk,
	input logic reset,
	input datapathControl control,
	input dataWord busData,
	input dataWord memAddress,
	input dataWord memDataOut,
	input dataWord instruction
);

	// First cycle out of reset
	resetClearsOutputs: assert property (@(posedge clk) $fell(reset) |->
		memAddress == '0 && memDataOut == '0 && instruction == '0)
		else $error("MAR, MDR or IR not zero after reset");

	idleBusIsZero: assert property (@(posedge clk) disable iff (reset)
		control.sources == '0 |-> busData == '0)
		else $error("Bus not zero with no source asserted");

	// A lone source strobe puts exactly that source on the bus
	mdrDrivesAlone: assert property (@(posedge clk) disable iff (reset)
		$onehot(control.sources) && control.sources.mdrOut |-> busData == memDataOut)
		else $error("Bus differs from MDR with only the MDR selected");

	zeroRegisterDrivesZero: assert property (@(posedge clk) disable iff (reset)
		$onehot(control.sources) && control.sources.registerOut[0] |-> busData == '0)
		else $error("R0 drove a nonzero value onto the bus");

endmodule

bind cpuDatapath cpuDatapathChk outputChecks (
	.clk(clk),
	.reset(reset),
	.control(control),
	.busData(busData),
	.memAddress(memAddress),
	.memDataOut(memDataOut),
	.instruction(instruction)
);

// File: testbench/cpuDatapathTb.sv
module cpuDatapathTb import datapathPkg::*; ();

	typedef enum int {srcNone, srcReg, srcHi, srcLo, srcZHigh, srcZLow, srcPc, srcMdr} sourceName;
	typedef enum int {toNone, toReg, toY, toZ, toHi, toLo, toPc, toMar, toMdr, toIr} sinkName;
	typedef enum int {seeMdr, seeMar, seeIr, seeBus, seeHigh, seeProduct} observeKind;

	// Cycle budget per sequence, used for the timeout
	localparam int resetCycles = 2;
	localparam int loadPathCycles = 1 + 7;
	localparam int operationCycles = 11 * 8;
	localparam int multiplyCycles = 3 * 10;
	localparam int pcCycles = 9;
	localparam int priorityCycles = 11 + 1;
	localparam int sequenceCycles = resetCycles + loadPathCycles + operationCycles
		+ multiplyCycles + pcCycles + priorityCycles;
	localparam int timeoutCycles = 2 * sequenceCycles;

	logic clk;
	logic reset;
	datapathControl control;
	dataWord memDataIn;
	dataWord busData;
	dataWord memAddress;
	dataWord memDataOut;
	dataWord instruction;

	logic [31:0] randomState;
	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	dataWord capturedHigh;
	observeKind kindQueue[$];
	string nameQueue[$];
	zResult expectQueue[$];

	cpuDatapath #(
		.registerCount(defaultRegisterCount)
	) dut (
		.clk(clk),
		.reset(reset),
		.control(control),
		.memDataIn(memDataIn),
		.busData(busData),
		.memAddress(memAddress),
		.memDataOut(memDataOut),
		.instruction(instruction)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic dataWord nextRandom();
		randomState ^= randomState << 13;
		randomState ^= randomState >> 17;
		randomState ^= randomState << 5;
		return randomState;
	endfunction

	// Expected Z contents for Y in a and the bus operand in b
	function automatic zResult expectedResult(aluOperation op, dataWord a, dataWord b);
		zResult r;
		int n;
		logic signed [63:0] product;
		r = '0;
		n = int'(b[4:0]);
		case (op)
			opAdd: r.low = a + b;
			opSub: r.low = a - b;
			opAnd: r.low = a & b;
			opOr: r.low = a | b;
			opShr: r.low = a >> n;
			opShra: r.low = a[31] ? ~(~a >> n) : a >> n;
			opShl: r.low = a << n;
			opRor: r.low = (a >> n) | (a << (32 - n));
			opRol: r.low = (a << n) | (a >> (32 - n));
			opNeg: r.low = 32'd0 - b;
			opNot: r.low = ~b;
			opMul: begin
				product = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
				r = product;
			end
			default: r = '0;
		endcase
		return r;
	endfunction

	function automatic busSources sourceOf(sourceName name, int index);
		busSources s;
		s = '0;
		case (name)
			srcReg: s.registerOut[index] = 1'b1;
			srcHi: s.hiOut = 1'b1;
			srcLo: s.loOut = 1'b1;
			srcZHigh: s.zHighOut = 1'b1;
			srcZLow: s.zLowOut = 1'b1;
			srcPc: s.pcOut = 1'b1;
			srcMdr: s.mdrOut = 1'b1;
			default: s = '0;
		endcase
		return s;
	endfunction

	function automatic busSinks sinkOf(sinkName name, int index);
		busSinks s;
		s = '0;
		case (name)
			toReg: s.registerIn[index] = 1'b1;
			toY: s.yIn = 1'b1;
			toZ: s.zIn = 1'b1;
			toHi: s.hiIn = 1'b1;
			toLo: s.loIn = 1'b1;
			toPc: s.pcIn = 1'b1;
			toMar: s.marIn = 1'b1;
			toMdr: s.mdrIn = 1'b1;
			toIr: s.irIn = 1'b1;
			default: s = '0;
		endcase
		return s;
	endfunction

	task automatic drive(busSources src, busSinks dst, aluOperation op, logic rd, logic inc,
		dataWord mem);
		@(posedge clk);
		control <= '{sources: src, sinks: dst, operation: op, read: rd, incPc: inc};
		memDataIn <= mem;
	endtask

	task automatic transfer(sourceName src, int srcIndex, sinkName dst, int dstIndex);
		drive(sourceOf(src, srcIndex), sinkOf(dst, dstIndex), opAdd, 1'b0, 1'b0, '0);
	endtask

	// Word arrives through the memory read path, then moves to the register
	task automatic loadRegister(int index, dataWord value);
		drive('0, sinkOf(toMdr, 0), opAdd, 1'b1, 1'b0, value);
		transfer(srcMdr, 0, toReg, index);
	endtask

	// Last transfer lands on this edge, results are visible until the next one
	task automatic idle();
		drive('0, '0, opAdd, 1'b0, 1'b0, '0);
	endtask

	task automatic runOperation(aluOperation op, dataWord a, dataWord b);
		loadRegister(1, a);
		loadRegister(2, b);
		transfer(srcReg, 1, toY, 0);
		drive(sourceOf(srcReg, 2), sinkOf(toZ, 0), op, 1'b0, 1'b0, '0);
	endtask

	task automatic expectResult(string name, observeKind kind, zResult value);
		kindQueue.push_back(kind);
		nameQueue.push_back(name);
		expectQueue.push_back(value);
	endtask

	task automatic expectWord(string name, observeKind kind, dataWord value);
		expectResult(name, kind, {32'd0, value});
	endtask

	task automatic compareWord(string name, dataWord expected, dataWord actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAIL %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic compareResult(string name, zResult expected, zResult actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAIL %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// Outputs are settled at the falling edge
	always @(negedge clk) begin
		observeKind kind;
		string name;
		zResult expected;
		while (kindQueue.size() > 0) begin
			kind = kindQueue.pop_front();
			name = nameQueue.pop_front();
			expected = expectQueue.pop_front();
			case (kind)
				seeMdr: compareWord(name, expected.low, memDataOut);
				seeMar: compareWord(name, expected.low, memAddress);
				seeIr: compareWord(name, expected.low, instruction);
				seeBus: compareWord(name, expected.low, busData);
				seeHigh: capturedHigh = memDataOut;
				seeProduct: compareResult(name, expected, {capturedHigh, memDataOut});
				default: ;
			endcase
		end
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount > timeoutCycles) begin
			$display("Timeout: stimulus still running after %0d cycles", cycleCount);
			$display("*** FAILED ***");
			$finish;
		end
	end

	initial begin
		dataWord a;
		dataWord b;
		dataWord value;
		zResult expected;
		aluOperation operation;
		randomState = 32'd72;
		reset <= 1'b1;
		control <= '0;
		memDataIn <= '0;
		repeat (resetCycles) @(posedge clk);
		reset <= 1'b0;

		idle();
		expectWord("reset bus", seeBus, '0);
		expectWord("reset mar", seeMar, '0);
		expectWord("reset mdr", seeMdr, '0);
		expectWord("reset ir", seeIr, '0);

		// Memory word through a register into MAR and IR, R0 must ignore its load
		value = nextRandom();
		loadRegister(5, value);
		transfer(srcReg, 5, toMar, 0);
		transfer(srcReg, 5, toIr, 0);
		transfer(srcMdr, 0, toReg, 0);
		transfer(srcReg, 0, toMdr, 0);
		idle();
		expectWord("load path mar", seeMar, value);
		expectWord("load path ir", seeIr, value);
		expectWord("r0 stays zero", seeMdr, '0);

		for (int op = opAdd; op <= opNot; op++) begin
			operation = aluOperation'(op);
			a = nextRandom();
			b = nextRandom();
			runOperation(operation, a, b);
			transfer(srcZLow, 0, toMdr, 0);
			idle();
			expected = expectedResult(operation, a, b);
			expectWord($sformatf("%s low word", operation.name()), seeMdr, expected.low);
		end

		for (int i = 0; i < 3; i++) begin
			a = nextRandom();
			b = nextRandom();
			if (i == 0) a[31] = 1'b1;
			runOperation(opMul, a, b);
			transfer(srcZHigh, 0, toMdr, 0);
			idle();
			expectWord("mul high half", seeHigh, '0);
			transfer(srcZLow, 0, toMdr, 0);
			idle();
			expected = expectedResult(opMul, a, b);
			expectResult($sformatf("mul product %0d", i), seeProduct, expected);
		end

		value = nextRandom();
		loadRegister(3, value);
		transfer(srcReg, 3, toPc, 0);
		repeat (3) drive('0, '0, opAdd, 1'b0, 1'b1, '0);
		// Increment beats the bus load here
		drive(sourceOf(srcReg, 3), sinkOf(toPc, 0), opAdd, 1'b0, 1'b1, '0);
		transfer(srcPc, 0, toMar, 0);
		idle();
		expectWord("pc increment", seeMar, value + 32'd4);

		// Z still holds the last product
		a = nextRandom();
		b = nextRandom();
		loadRegister(2, a);
		loadRegister(4, b);
		transfer(srcReg, 4, toHi, 0);
		drive(sourceOf(srcReg, 2) | sourceOf(srcHi, 0), sinkOf(toMdr, 0), opAdd, 1'b0, 1'b0, '0);
		idle();
		expectWord("register over hi", seeMdr, a);
		drive(sourceOf(srcHi, 0) | sourceOf(srcMdr, 0), sinkOf(toMar, 0), opAdd, 1'b0, 1'b0, '0);
		idle();
		expectWord("hi over mdr", seeMar, b);
		drive(sourceOf(srcZLow, 0) | sourceOf(srcPc, 0), sinkOf(toIr, 0), opAdd, 1'b0, 1'b0, '0);
		idle();
		expectWord("z low over pc", seeIr, expected.low);

		@(posedge clk);
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: sim.f
hw/datapathPkg.sv
hw/busRegister.sv
hw/registerFile.sv
hw/programCounter.sv
hw/memoryInterface.sv
hw/busSelector.sv
hw/arithmeticUnit.sv
hw/cpuDatapath.sv
testbench/cpuDatapath_chk.sv
testbench/cpuDatapathTb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile the datapath testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module cpuDatapathTb -o simCpuDatapath
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/simCpuDatapath)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qF '*** PASSED ***'; then
	exit 0
fi
exit 1
